// ==== design/proc_cfg.svh ====
/*
 * processor configuration
 * word width, register count and the first fetch address
 */

`ifndef PROC_CFG_SVH
`define PROC_CFG_SVH

// data and address width
`define PROC_XLEN 32

// architectural registers, r0 included
`define PROC_NREGS 32

// pc after reset
`define PROC_RESET_VECTOR 32'h0000_1000

`endif

// ==== design/proc_pkg.sv ====
/*
 * processor package
 * instruction formats, opcode and funct encodings, datapath select types
 */

`include "proc_cfg.svh"

package proc_pkg;

  typedef logic [`PROC_XLEN-1:0]          word_t;
  typedef logic [$clog2(`PROC_NREGS)-1:0] reg_idx_t;

  // ---------------------------------------------------------------------
  // encodings of the kept subset
  // ---------------------------------------------------------------------

  typedef enum logic [5:0] {
    OP_SPECIAL = 6'h00,
    OP_JAL     = 6'h03,
    OP_BNE     = 6'h05,
    OP_ADDIU   = 6'h09,
    OP_COP0    = 6'h10,
    OP_LW      = 6'h23,
    OP_SW      = 6'h2b
  } opcode_t;

  typedef enum logic [5:0] {
    FN_JR   = 6'h08,
    FN_ADDU = 6'h21,
    FN_SUBU = 6'h23,
    FN_AND  = 6'h24,
    FN_OR   = 6'h25
  } funct_t;

  // rs field of cop0 ops picks the direction
  localparam reg_idx_t COP0_MF = 5'h00;
  localparam reg_idx_t COP0_MT = 5'h04;

  // ---------------------------------------------------------------------
  // one instruction word, three views
  // ---------------------------------------------------------------------

  typedef struct packed {
    opcode_t  opcode;
    reg_idx_t rs;
    reg_idx_t rt;
    reg_idx_t rd;
    logic [4:0] shamt;
    funct_t   funct;
  } r_fmt_t;

  typedef struct packed {
    opcode_t     opcode;
    reg_idx_t    rs;
    reg_idx_t    rt;
    logic [15:0] imm;
  } i_fmt_t;

  typedef struct packed {
    opcode_t     opcode;
    logic [25:0] target;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    j_fmt_t j;
  } pisa_inst_t;

  // ---------------------------------------------------------------------
  // datapath selects
  // ---------------------------------------------------------------------

  typedef enum logic [1:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR} alu_fn_t;
  typedef enum logic {OPB_RT, OPB_IMM} opb_sel_t;
  typedef enum logic [1:0] {WB_ALU, WB_LOAD, WB_MNGR, WB_PC4} wb_sel_t;
  typedef enum logic [1:0] {PC_SEQ, PC_BR, PC_JUMP, PC_REG} pc_sel_t;
  typedef enum logic [1:0] {WA_RD, WA_RT, WA_R31} waddr_sel_t;

endpackage

// ==== design/proc_ctrl_if.sv ====
/*
 * control/status bundle between the control FSM and the datapath
 */

`timescale 1ns/1ns

interface proc_ctrl_if
  import proc_pkg::*;
();

  // register enables
  logic       ir_en;
  logic       pc_en;
  logic       rf_wen;
  logic       mngr_en;

  // mux selects
  opb_sel_t   opb_sel;
  wb_sel_t    wb_sel;
  alu_fn_t    alu_fn;
  pc_sel_t    pc_sel;
  waddr_sel_t rf_waddr_sel;

  // status back to control
  pisa_inst_t inst;
  logic       br_ne;

  modport ctrl (
    output ir_en, pc_en, rf_wen, mngr_en,
    output opb_sel, wb_sel, alu_fn, pc_sel, rf_waddr_sel,
    input  inst, br_ne
  );

  modport dp (
    input  ir_en, pc_en, rf_wen, mngr_en,
    input  opb_sel, wb_sel, alu_fn, pc_sel, rf_waddr_sel,
    output inst, br_ne
  );

endinterface

// ==== design/proc_alu.sv ====
/*
 * ALU
 * add, subtract, and, or, plus the not-equal flag used by bne
 */

`timescale 1ns/1ns

module proc_alu
  import proc_pkg::*;
(
  input  alu_fn_t fn,
  input  word_t   a,
  input  word_t   b,
  output word_t   result,
  output logic    ne
);

  always_comb
  begin
    case (fn)
      ALU_SUB: result = a - b;
      ALU_AND: result = a & b;
      ALU_OR:  result = a | b;
      // addu, addiu and lw/sw address
      default: result = a + b;
    endcase
  end

  // independent of fn
  assign ne = (a != b);

endmodule

// ==== design/proc_regfile.sv ====
/*
 * register file
 * two combinational read ports, one write port, r0 hardwired to zero
 */

`timescale 1ns/1ns
`include "proc_cfg.svh"

module proc_regfile
  import proc_pkg::*;
(
  input  logic     clk,
  input  reg_idx_t raddr0,
  output word_t    rdata0,
  input  reg_idx_t raddr1,
  output word_t    rdata1,
  input  logic     wen,
  input  reg_idx_t waddr,
  input  word_t    wdata
);

  // no storage behind r0
  word_t regs [1:`PROC_NREGS-1];

  always_ff @(posedge clk)
  begin
    if (wen && (waddr != '0))
      regs[waddr] <= wdata;
  end

  assign rdata0 = (raddr0 == '0) ? '0 : regs[raddr0];
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];

endmodule

// ==== design/proc_dpath.sv ====
/*
 * multicycle datapath
 * pc and instruction register, operand and writeback muxes,
 * next-pc selection, register file and ALU
 */

`timescale 1ns/1ns
`include "proc_cfg.svh"

module proc_dpath
  import proc_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  proc_ctrl_if.dp dp,
  output word_t   imemreq_addr,
  input  word_t   imemresp_data,
  output word_t   dmemreq_addr,
  output word_t   dmemreq_wdata,
  input  word_t   dmemresp_data,
  input  word_t   from_mngr_data,
  output word_t   to_mngr_data
);

  word_t      pc_q;
  pisa_inst_t ir_q;
  word_t      mngr_q, load_q;
  word_t      rs_val, rt_val;
  word_t      imm_sext, opb, alu_result;
  word_t      pc_plus4, br_target, j_target, pc_next, wb_data;
  reg_idx_t   waddr;

  // ---------------------------------------------------------------------
  // state registers
  // ---------------------------------------------------------------------

  always_ff @(posedge clk)
  begin
    if (rst)
      pc_q <= `PROC_RESET_VECTOR;
    else if (dp.pc_en)
      pc_q <= pc_next;
  end

  always_ff @(posedge clk)
  begin
    if (dp.ir_en)
      ir_q <= imemresp_data;
    // both captured, wb_sel picks the live one
    if (dp.mngr_en)
    begin
      mngr_q <= from_mngr_data;
      load_q <= dmemresp_data;
    end
  end

  assign dp.inst = ir_q;

  // ---------------------------------------------------------------------
  // operands and execute
  // ---------------------------------------------------------------------

  assign imm_sext = {{(`PROC_XLEN-16){ir_q.i.imm[15]}}, ir_q.i.imm};
  assign opb      = (dp.opb_sel == OPB_IMM) ? imm_sext : rt_val;

  always_comb
  begin
    case (dp.rf_waddr_sel)
      WA_RD:   waddr = ir_q.r.rd;
      WA_R31:  waddr = reg_idx_t'(`PROC_NREGS-1);
      default: waddr = ir_q.r.rt;
    endcase
  end

  proc_regfile u_regfile (
    .clk    (clk),
    .raddr0 (ir_q.r.rs),
    .rdata0 (rs_val),
    .raddr1 (ir_q.r.rt),
    .rdata1 (rt_val),
    .wen    (dp.rf_wen),
    .waddr  (waddr),
    .wdata  (wb_data)
  );

  proc_alu u_alu (
    .fn     (dp.alu_fn),
    .a      (rs_val),
    .b      (opb),
    .result (alu_result),
    .ne     (dp.br_ne)
  );

  // ---------------------------------------------------------------------
  // next pc and writeback
  // ---------------------------------------------------------------------

  assign pc_plus4  = pc_q + word_t'(4);
  assign br_target = pc_plus4 + {imm_sext[`PROC_XLEN-3:0], 2'b00};
  // upper bits of the next pc plus the word index
  assign j_target  = {pc_plus4[`PROC_XLEN-1 -: 4], ir_q.j.target, 2'b00};

  always_comb
  begin
    case (dp.pc_sel)
      PC_BR:   pc_next = br_target;
      PC_JUMP: pc_next = j_target;
      PC_REG:  pc_next = rs_val;
      default: pc_next = pc_plus4;
    endcase
  end

  always_comb
  begin
    case (dp.wb_sel)
      WB_LOAD: wb_data = load_q;
      WB_MNGR: wb_data = mngr_q;
      WB_PC4:  wb_data = pc_plus4;
      default: wb_data = alu_result;
    endcase
  end

  // outbound payloads, stable while IR and registers hold
  assign imemreq_addr  = pc_q;
  assign dmemreq_addr  = alu_result;
  assign dmemreq_wdata = rt_val;
  assign to_mngr_data  = rt_val;

endmodule

// ==== design/proc_ctrl.sv ====
/*
 * multicycle control unit
 * steps one instruction at a time through fetch, decode, memory or manager
 * access and writeback, and drives every handshake toward the outside
 */

`timescale 1ns/1ns

module proc_ctrl
  import proc_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  proc_ctrl_if.ctrl ctrl,
  output logic      imemreq_val,
  input  logic      imemreq_rdy,
  input  logic      imemresp_val,
  output logic      imemresp_rdy,
  output logic      dmemreq_val,
  input  logic      dmemreq_rdy,
  output logic      dmemreq_wen,
  input  logic      dmemresp_val,
  output logic      dmemresp_rdy,
  input  logic      from_mngr_val,
  output logic      from_mngr_rdy,
  output logic      to_mngr_val,
  input  logic      to_mngr_rdy
);

  typedef enum logic [2:0] {
    S_IDLE, S_FETCH, S_WAIT_I, S_DECODE, S_MEM, S_WAIT_D, S_MNGR, S_WB
  } state_t;

  state_t  state, state_next;
  opcode_t opcode;
  funct_t  funct;
  logic    is_mem, is_sw, is_mf, is_mt;
  logic    writes_rf;

  // ---------------------------------------------------------------------
  // decode, held stable by the IR for the whole instruction
  // ---------------------------------------------------------------------

  assign opcode = ctrl.inst.r.opcode;
  assign funct  = ctrl.inst.r.funct;
  assign is_sw  = (opcode == OP_SW);
  assign is_mem = (opcode == OP_LW) || is_sw;
  assign is_mt  = (opcode == OP_COP0) && (ctrl.inst.r.rs == COP0_MT);
  assign is_mf  = (opcode == OP_COP0) && (ctrl.inst.r.rs == COP0_MF);

  always_comb
  begin
    ctrl.alu_fn       = ALU_ADD;
    ctrl.opb_sel      = OPB_RT;
    ctrl.wb_sel       = WB_ALU;
    ctrl.pc_sel       = PC_SEQ;
    ctrl.rf_waddr_sel = WA_RT;
    writes_rf         = 1'b0;
    case (opcode)
      OP_SPECIAL:
      begin
        ctrl.rf_waddr_sel = WA_RD;
        case (funct)
          FN_ADDU: writes_rf = 1'b1;
          FN_SUBU:
          begin
            ctrl.alu_fn = ALU_SUB;
            writes_rf   = 1'b1;
          end
          FN_AND:
          begin
            ctrl.alu_fn = ALU_AND;
            writes_rf   = 1'b1;
          end
          FN_OR:
          begin
            ctrl.alu_fn = ALU_OR;
            writes_rf   = 1'b1;
          end
          // target comes straight from rs
          FN_JR:   ctrl.pc_sel = PC_REG;
          default: writes_rf = 1'b0;
        endcase
      end
      OP_ADDIU:
      begin
        ctrl.opb_sel = OPB_IMM;
        writes_rf    = 1'b1;
      end
      OP_LW:
      begin
        ctrl.opb_sel = OPB_IMM;
        ctrl.wb_sel  = WB_LOAD;
        writes_rf    = 1'b1;
      end
      // address only, rt goes out as store data
      OP_SW:  ctrl.opb_sel = OPB_IMM;
      // not-equal flag compares rs with rt
      OP_BNE: ctrl.pc_sel = ctrl.br_ne ? PC_BR : PC_SEQ;
      OP_JAL:
      begin
        ctrl.pc_sel       = PC_JUMP;
        ctrl.wb_sel       = WB_PC4;
        ctrl.rf_waddr_sel = WA_R31;
        writes_rf         = 1'b1;
      end
      OP_COP0:
      begin
        ctrl.wb_sel = WB_MNGR;
        writes_rf   = is_mf;
      end
      default: writes_rf = 1'b0;
    endcase
  end

  // ---------------------------------------------------------------------
  // state machine
  // ---------------------------------------------------------------------

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= S_IDLE;
    else
      state <= state_next;
  end

  always_comb
  begin
    state_next = state;
    case (state)
      S_IDLE:   state_next = S_FETCH;
      S_FETCH:  if (imemreq_rdy) state_next = S_WAIT_I;
      S_WAIT_I: if (imemresp_val) state_next = S_DECODE;
      S_DECODE:
      begin
        if (is_mem)
          state_next = S_MEM;
        else if (is_mf || is_mt)
          state_next = S_MNGR;
        else
          state_next = S_WB;
      end
      S_MEM:    if (dmemreq_rdy) state_next = S_WAIT_D;
      S_WAIT_D: if (dmemresp_val) state_next = S_WB;
      S_MNGR:
      begin
        if ((is_mf && from_mngr_val) || (is_mt && to_mngr_rdy))
          state_next = S_WB;
      end
      S_WB:     state_next = S_FETCH;
      default:  state_next = S_IDLE;
    endcase
  end

  // handshakes follow the state alone
  assign imemreq_val   = (state == S_FETCH);
  assign imemresp_rdy  = (state == S_WAIT_I);
  assign dmemreq_val   = (state == S_MEM);
  assign dmemreq_wen   = (state == S_MEM) && is_sw;
  assign dmemresp_rdy  = (state == S_WAIT_D);
  assign from_mngr_rdy = (state == S_MNGR) && is_mf;
  assign to_mngr_val   = (state == S_MNGR) && is_mt;

  // datapath enables
  assign ctrl.ir_en   = (state == S_WAIT_I) && imemresp_val;
  assign ctrl.pc_en   = (state == S_WB);
  assign ctrl.rf_wen  = (state == S_WB) && writes_rf;
  // load data or manager value, whichever transfers
  assign ctrl.mngr_en = ((state == S_WAIT_D) && dmemresp_val)
                      || (from_mngr_rdy && from_mngr_val);

  // ---------------------------------------------------------------------
  // protocol checks
  // ---------------------------------------------------------------------

  // an offered request is never withdrawn before it transfers
  a_imemreq_hold: assert property (@(posedge clk) disable iff (rst)
    imemreq_val && !imemreq_rdy |=> imemreq_val);
  a_dmemreq_hold: assert property (@(posedge clk) disable iff (rst)
    dmemreq_val && !dmemreq_rdy |=> dmemreq_val);
  a_to_mngr_hold: assert property (@(posedge clk) disable iff (rst)
    to_mngr_val && !to_mngr_rdy |=> to_mngr_val);

  // decode is a single cycle, writeback always returns to fetch
  a_decode_once: assert property (@(posedge clk) disable iff (rst)
    state == S_DECODE |=> state inside {S_MEM, S_MNGR, S_WB});
  a_wb_to_fetch: assert property (@(posedge clk) disable iff (rst)
    state == S_WB |=> state == S_FETCH);

endmodule

// ==== design/proc_top.sv ====
/*
 * processor top level
 * control FSM and datapath joined by the control bundle,
 * memory and manager channels exposed as plain ports
 */

`timescale 1ns/1ns

module proc_top (
  input  logic        clk,
  input  logic        rst,
  // instruction memory
  output logic        imemreq_val,
  input  logic        imemreq_rdy,
  output logic [31:0] imemreq_addr,
  input  logic        imemresp_val,
  output logic        imemresp_rdy,
  input  logic [31:0] imemresp_data,
  // data memory
  output logic        dmemreq_val,
  input  logic        dmemreq_rdy,
  output logic        dmemreq_wen,
  output logic [31:0] dmemreq_addr,
  output logic [31:0] dmemreq_wdata,
  input  logic        dmemresp_val,
  output logic        dmemresp_rdy,
  input  logic [31:0] dmemresp_data,
  // manager source and sink
  input  logic        from_mngr_val,
  output logic        from_mngr_rdy,
  input  logic [31:0] from_mngr_data,
  output logic        to_mngr_val,
  input  logic        to_mngr_rdy,
  output logic [31:0] to_mngr_data
);

  proc_ctrl_if cif ();

  // all val/rdy from control
  proc_ctrl u_ctrl (
    .clk           (clk),
    .rst           (rst),
    .ctrl          (cif.ctrl),
    .imemreq_val   (imemreq_val),
    .imemreq_rdy   (imemreq_rdy),
    .imemresp_val  (imemresp_val),
    .imemresp_rdy  (imemresp_rdy),
    .dmemreq_val   (dmemreq_val),
    .dmemreq_rdy   (dmemreq_rdy),
    .dmemreq_wen   (dmemreq_wen),
    .dmemresp_val  (dmemresp_val),
    .dmemresp_rdy  (dmemresp_rdy),
    .from_mngr_val (from_mngr_val),
    .from_mngr_rdy (from_mngr_rdy),
    .to_mngr_val   (to_mngr_val),
    .to_mngr_rdy   (to_mngr_rdy)
  );

  // addresses and data from the datapath
  proc_dpath u_dpath (
    .clk            (clk),
    .rst            (rst),
    .dp             (cif.dp),
    .imemreq_addr   (imemreq_addr),
    .imemresp_data  (imemresp_data),
    .dmemreq_addr   (dmemreq_addr),
    .dmemreq_wdata  (dmemreq_wdata),
    .dmemresp_data  (dmemresp_data),
    .from_mngr_data (from_mngr_data),
    .to_mngr_data   (to_mngr_data)
  );

endmodule

// ==== testbench/proc_tb_mem.sv ====
/*
 * word memory model for the testbench
 * serves the instruction and data ports with random response delays,
 * reports every store request that transfers
 */

`timescale 1ns/1ns

module proc_tb_mem
  import proc_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  logic  heavy,
  input  logic  imemreq_val,
  output logic  imemreq_rdy,
  input  word_t imemreq_addr,
  output logic  imemresp_val,
  input  logic  imemresp_rdy,
  output word_t imemresp_data,
  input  logic  dmemreq_val,
  output logic  dmemreq_rdy,
  input  logic  dmemreq_wen,
  input  word_t dmemreq_addr,
  input  word_t dmemreq_wdata,
  output logic  dmemresp_val,
  input  logic  dmemresp_rdy,
  output word_t dmemresp_data,
  output logic  st_fire,
  output word_t st_addr,
  output word_t st_data
);

  // 16 KB, word indexed by addr[13:2]
  word_t  mem [0:4095];
  integer seed = 32'hb03c30df;

  function automatic int pick_delay();
    return heavy ? ($random(seed) & 7) : ($random(seed) & 1);
  endfunction

  // heavy mode is ready one cycle in four
  function automatic logic pick_rdy();
    return heavy ? (($random(seed) & 3) == 0) : 1'b1;
  endfunction

  // ---------------------------------------------------------------------
  // instruction port
  // ---------------------------------------------------------------------

  initial
  begin : imem_port
    logic  req_fire;
    logic  resp_fire;
    logic  busy;
    int    dly;
    word_t data;
    imemreq_rdy   = 1'b0;
    imemresp_val  = 1'b0;
    imemresp_data = '0;
    busy          = 1'b0;
    dly           = 0;
    data          = '0;
    forever
    begin
      @(posedge clk);
      // sampled at the edge, before the DUT updates
      req_fire  = imemreq_val && imemreq_rdy;
      resp_fire = imemresp_val && imemresp_rdy;
      if (req_fire)
        data = mem[imemreq_addr[13:2]];
      #2;
      if (rst)
      begin
        busy         = 1'b0;
        imemresp_val = 1'b0;
      end
      else
      begin
        if (resp_fire)
        begin
          imemresp_val = 1'b0;
          busy         = 1'b0;
        end
        if (req_fire)
        begin
          busy = 1'b1;
          dly  = pick_delay();
        end
        if (busy && !imemresp_val)
        begin
          if (dly == 0)
          begin
            imemresp_val  = 1'b1;
            imemresp_data = data;
          end
          else
            dly--;
        end
      end
      imemreq_rdy = !rst && !busy && pick_rdy();
    end
  end

  // ---------------------------------------------------------------------
  // data port with store monitor
  // ---------------------------------------------------------------------

  initial
  begin : dmem_port
    logic  req_fire;
    logic  resp_fire;
    logic  busy;
    logic  wr;
    int    dly;
    word_t data;
    word_t addr;
    word_t wdata;
    dmemreq_rdy   = 1'b0;
    dmemresp_val  = 1'b0;
    dmemresp_data = '0;
    st_fire       = 1'b0;
    st_addr       = '0;
    st_data       = '0;
    busy          = 1'b0;
    wr            = 1'b0;
    dly           = 0;
    data          = '0;
    addr          = '0;
    wdata         = '0;
    forever
    begin
      @(posedge clk);
      req_fire  = dmemreq_val && dmemreq_rdy;
      resp_fire = dmemresp_val && dmemresp_rdy;
      if (req_fire)
      begin
        wr    = dmemreq_wen;
        addr  = dmemreq_addr;
        wdata = dmemreq_wdata;
        data  = mem[addr[13:2]];
        // stores write at once, the response data is a don't care
        if (wr)
          mem[addr[13:2]] = wdata;
      end
      #2;
      st_fire = 1'b0;
      if (rst)
      begin
        busy         = 1'b0;
        dmemresp_val = 1'b0;
      end
      else
      begin
        if (resp_fire)
        begin
          dmemresp_val = 1'b0;
          busy         = 1'b0;
        end
        if (req_fire)
        begin
          busy    = 1'b1;
          dly     = pick_delay();
          st_fire = wr;
          st_addr = addr;
          st_data = wdata;
        end
        if (busy && !dmemresp_val)
        begin
          if (dly == 0)
          begin
            dmemresp_val  = 1'b1;
            dmemresp_data = data;
          end
          else
            dly--;
        end
      end
      dmemreq_rdy = !rst && !busy && pick_rdy();
    end
  end

endmodule

// ==== testbench/proc_tb.sv ====
/*
 * processor testbench
 * runs one program twice, light then heavy back-pressure, and checks
 * manager output and stores against an ISA-level reference
 */

`timescale 1ns/1ns
`include "proc_cfg.svh"

module proc_tb
  import proc_pkg::*;
;

  localparam int    TIMEOUT = 20000;
  localparam word_t END_PC  = `PROC_RESET_VECTOR + 32'd144;

  logic  clk, rst, heavy;
  logic  imemreq_val, imemreq_rdy, imemresp_val, imemresp_rdy;
  word_t imemreq_addr, imemresp_data;
  logic  dmemreq_val, dmemreq_rdy, dmemreq_wen, dmemresp_val, dmemresp_rdy;
  word_t dmemreq_addr, dmemreq_wdata, dmemresp_data;
  logic  from_mngr_val, from_mngr_rdy, to_mngr_val, to_mngr_rdy;
  word_t from_mngr_data, to_mngr_data;
  logic  st_fire;
  word_t st_addr, st_data;

  word_t  img [$];
  word_t  ref_mem [0:4095];
  word_t  src_q [$];
  word_t  exp_mngr [$];
  word_t  exp_st_a [$];
  word_t  exp_st_d [$];
  int     got_mngr, got_st;
  integer seed = 32'hb03c30df;

  proc_top uut (.*);

  proc_tb_mem u_mem (.*);

  initial
  begin
    clk = 1'b0;
    forever
      #20 clk = ~clk;
  end

  // ---------------------------------------------------------------------
  // failure reporting and typed compares
  // ---------------------------------------------------------------------

  task automatic report_fail(input string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp)
      report_fail($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_addr(input string name, input word_t got, input word_t exp);
    if (got !== exp)
      report_fail($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
  endtask

  // ---------------------------------------------------------------------
  // instruction encoders
  // ---------------------------------------------------------------------

  function automatic word_t enc_r(funct_t fn, reg_idx_t rs, reg_idx_t rt, reg_idx_t rd);
    pisa_inst_t w;
    w          = '0;
    w.r.opcode = OP_SPECIAL;
    w.r.rs     = rs;
    w.r.rt     = rt;
    w.r.rd     = rd;
    w.r.funct  = fn;
    return w;
  endfunction

  function automatic word_t enc_i(opcode_t op, reg_idx_t rs, reg_idx_t rt, logic [15:0] imm);
    pisa_inst_t w;
    w.i.opcode = op;
    w.i.rs     = rs;
    w.i.rt     = rt;
    w.i.imm    = imm;
    return w;
  endfunction

  // target given as a word slot of the program
  function automatic word_t enc_jal(int slot);
    pisa_inst_t w;
    word_t      a;
    a          = `PROC_RESET_VECTOR + word_t'(slot * 4);
    w.j.opcode = OP_JAL;
    w.j.target = a[27:2];
    return w;
  endfunction

  function automatic word_t enc_cop0(reg_idx_t dir, reg_idx_t rt);
    pisa_inst_t w;
    w          = '0;
    w.r.opcode = OP_COP0;
    w.r.rs     = dir;
    w.r.rt     = rt;
    return w;
  endfunction

  task automatic build_program();
    img.delete();
    img.push_back(enc_cop0(COP0_MF, 1));
    img.push_back(enc_cop0(COP0_MF, 2));
    img.push_back(enc_r(FN_ADDU, 1, 2, 3));
    img.push_back(enc_cop0(COP0_MT, 3));
    img.push_back(enc_r(FN_SUBU, 1, 2, 4));
    img.push_back(enc_cop0(COP0_MT, 4));
    img.push_back(enc_r(FN_AND, 1, 2, 5));
    img.push_back(enc_cop0(COP0_MT, 5));
    img.push_back(enc_r(FN_OR, 1, 2, 6));
    img.push_back(enc_cop0(COP0_MT, 6));
    // source is destination, both sources the same register
    img.push_back(enc_r(FN_ADDU, 1, 1, 1));
    img.push_back(enc_cop0(COP0_MT, 1));
    img.push_back(enc_r(FN_SUBU, 2, 2, 7));
    img.push_back(enc_cop0(COP0_MT, 7));
    // negative immediates
    img.push_back(enc_i(OP_ADDIU, 0, 8, 16'hfffb));
    img.push_back(enc_cop0(COP0_MT, 8));
    img.push_back(enc_i(OP_ADDIU, 8, 8, 16'h8000));
    img.push_back(enc_cop0(COP0_MT, 8));
    // store and load round trips around a base of 0x2000
    img.push_back(enc_i(OP_ADDIU, 0, 9, 16'h2000));
    img.push_back(enc_i(OP_SW, 9, 3, 16'h0004));
    img.push_back(enc_i(OP_SW, 9, 2, 16'hfffc));
    img.push_back(enc_i(OP_LW, 9, 10, 16'h0004));
    img.push_back(enc_cop0(COP0_MT, 10));
    img.push_back(enc_i(OP_LW, 9, 11, 16'hfffc));
    img.push_back(enc_cop0(COP0_MT, 11));
    // bne not taken, then taken forward over a poison send
    img.push_back(enc_i(OP_BNE, 3, 3, 16'h0001));
    img.push_back(enc_cop0(COP0_MT, 2));
    img.push_back(enc_i(OP_BNE, 8, 0, 16'h0001));
    img.push_back(enc_cop0(COP0_MT, 0));
    img.push_back(enc_cop0(COP0_MT, 4));
    // backward loop, counts 2, 1, 0
    img.push_back(enc_i(OP_ADDIU, 0, 12, 16'h0003));
    img.push_back(enc_i(OP_ADDIU, 12, 12, 16'hffff));
    img.push_back(enc_cop0(COP0_MT, 12));
    img.push_back(enc_i(OP_BNE, 12, 0, 16'hfffd));
    // call into slot 40, return to 35, then spin at 36
    img.push_back(enc_jal(40));
    img.push_back(enc_cop0(COP0_MT, 3));
    img.push_back(enc_jal(36));
    img.push_back(enc_r(FN_OR, 0, 0, 0));
    img.push_back(enc_r(FN_OR, 0, 0, 0));
    img.push_back(enc_r(FN_OR, 0, 0, 0));
    img.push_back(enc_cop0(COP0_MT, 31));
    img.push_back(enc_r(FN_JR, 31, 0, 0));
  endtask

  // same image into the model memory and the reference memory
  task automatic load_image();
    word_t fill;
    for (int i = 0; i < 4096; i++)
    begin
      fill          = 32'h5a5a_0000 ^ word_t'(i * 4);
      ref_mem[i]    = fill;
      u_mem.mem[i]  = fill;
    end
    for (int i = 0; i < img.size(); i++)
    begin
      ref_mem[1024 + i]   = img[i];
      u_mem.mem[1024 + i] = img[i];
    end
  endtask

  // ---------------------------------------------------------------------
  // ISA reference, runs until the spin slot
  // ---------------------------------------------------------------------

  function automatic void ref_run();
    word_t      r [`PROC_NREGS];
    word_t      pc, npc, sext, a;
    pisa_inst_t in;
    int         si;
    for (int k = 0; k < `PROC_NREGS; k++)
      r[k] = '0;
    pc = `PROC_RESET_VECTOR;
    si = 0;
    exp_mngr.delete();
    exp_st_a.delete();
    exp_st_d.delete();
    for (int step = 0; step < 1000 && pc != END_PC; step++)
    begin
      in   = ref_mem[pc[13:2]];
      npc  = pc + 32'd4;
      sext = {{16{in.i.imm[15]}}, in.i.imm};
      a    = r[in.i.rs] + sext;
      case (in.r.opcode)
        OP_SPECIAL:
        begin
          case (in.r.funct)
            FN_ADDU: r[in.r.rd] = r[in.r.rs] + r[in.r.rt];
            FN_SUBU: r[in.r.rd] = r[in.r.rs] - r[in.r.rt];
            FN_AND:  r[in.r.rd] = r[in.r.rs] & r[in.r.rt];
            FN_OR:   r[in.r.rd] = r[in.r.rs] | r[in.r.rt];
            FN_JR:   npc = r[in.r.rs];
            default: ;
          endcase
        end
        OP_ADDIU: r[in.i.rt] = a;
        OP_LW:    r[in.i.rt] = ref_mem[a[13:2]];
        OP_SW:
        begin
          ref_mem[a[13:2]] = r[in.i.rt];
          exp_st_a.push_back(a);
          exp_st_d.push_back(r[in.i.rt]);
        end
        OP_BNE:   if (r[in.i.rs] != r[in.i.rt]) npc = npc + {sext[29:0], 2'b00};
        OP_JAL:
        begin
          r[31] = npc;
          npc   = {npc[31:28], in.j.target, 2'b00};
        end
        OP_COP0:
        begin
          if (in.r.rs == COP0_MF)
          begin
            r[in.r.rt] = src_q[si];
            si++;
          end
          else
            exp_mngr.push_back(r[in.r.rt]);
        end
        default: ;
      endcase
      r[0] = '0;
      pc   = npc;
    end
  endfunction

  // ---------------------------------------------------------------------
  // manager source and sink
  // ---------------------------------------------------------------------

  initial
  begin : mngr_source
    int idx;
    int gap;
    from_mngr_val  = 1'b0;
    from_mngr_data = '0;
    idx            = 0;
    gap            = 0;
    forever
    begin
      @(posedge clk);
      if (rst)
        idx = 0;
      else if (from_mngr_val && from_mngr_rdy)
      begin
        idx++;
        gap = heavy ? ($random(seed) & 7) : 0;
      end
      #2;
      if (gap > 0)
      begin
        gap--;
        from_mngr_val = 1'b0;
      end
      else if (!rst && idx < src_q.size())
      begin
        from_mngr_val  = 1'b1;
        from_mngr_data = src_q[idx];
      end
      else
        from_mngr_val = 1'b0;
    end
  end

  initial
  begin : mngr_sink
    to_mngr_rdy = 1'b0;
    forever
    begin
      @(posedge clk);
      #2;
      to_mngr_rdy = heavy ? (($random(seed) & 3) == 0) : 1'b1;
    end
  end

  // ---------------------------------------------------------------------
  // compare process
  // ---------------------------------------------------------------------

  always @(posedge clk)
  begin
    if (!rst && to_mngr_val && to_mngr_rdy)
    begin
      if (got_mngr >= exp_mngr.size())
        report_fail("an extra value was sent to the manager");
      else
        check_word("to_mngr_data", to_mngr_data, exp_mngr[got_mngr]);
      got_mngr++;
    end
    if (!rst && st_fire)
    begin
      if (got_st >= exp_st_a.size())
        report_fail("an unexpected store reached data memory");
      else
      begin
        check_addr("dmemreq_addr", st_addr, exp_st_a[got_st]);
        check_word("dmemreq_wdata", st_data, exp_st_d[got_st]);
      end
      got_st++;
    end
  end

  // ---------------------------------------------------------------------
  // main sequence
  // ---------------------------------------------------------------------

  initial
  begin
    int cyc;
    rst      = 1'b1;
    heavy    = 1'b0;
    got_mngr = 0;
    got_st   = 0;
    build_program();
    for (int run = 0; run < 2; run++)
    begin
      @(posedge clk);
      #2;
      rst   = 1'b1;
      heavy = (run == 1);
      src_q.delete();
      src_q.push_back($random(seed));
      src_q.push_back($random(seed));
      load_image();
      ref_run();
      got_mngr = 0;
      got_st   = 0;
      repeat (8)
      begin
        @(posedge clk);
        #2;
        if (imemreq_val || dmemreq_val || to_mngr_val || from_mngr_rdy
            || imemresp_rdy || dmemresp_rdy)
          report_fail("a valid or ready output was high during reset");
      end
      rst = 1'b0;
      cyc = 0;
      while (!imemreq_val && cyc < TIMEOUT)
      begin
        @(negedge clk);
        cyc++;
      end
      if (cyc >= TIMEOUT)
        report_fail("timeout waiting for the first fetch");
      check_addr("imemreq_addr", imemreq_addr, `PROC_RESET_VECTOR);
      cyc = 0;
      while ((got_mngr < exp_mngr.size() || got_st < exp_st_a.size()) && cyc < TIMEOUT)
      begin
        @(negedge clk);
        cyc++;
      end
      if (cyc >= TIMEOUT)
        report_fail("timeout waiting for manager values and stores");
      // spin slot fetched only after the last send has retired
      cyc = 0;
      while (!(imemreq_val && imemreq_addr == END_PC) && cyc < TIMEOUT)
      begin
        @(negedge clk);
        cyc++;
      end
      if (cyc >= TIMEOUT)
        report_fail("timeout waiting for the program to reach its spin loop");
    end
    $display("No errors");
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+design
design/proc_pkg.sv
design/proc_ctrl_if.sv
design/proc_alu.sv
design/proc_regfile.sv
design/proc_dpath.sv
design/proc_ctrl.sv
design/proc_top.sv
testbench/proc_tb_mem.sv
testbench/proc_tb.sv

// ==== Makefile ====
# Verilator build and run for the multicycle processor testbench

SRCS := $(wildcard design/*.sv design/*.svh testbench/*.sv)

.PHONY: run clean

obj_dir/Vproc_tb: project.f $(SRCS)
	verilator --binary --timing --assert --top-module proc_tb -f project.f -o Vproc_tb

run: obj_dir/Vproc_tb
	./obj_dir/Vproc_tb > sim.log 2>&1 || true
	cat sim.log
	! grep -q "Errors found" sim.log
	grep -q "No errors" sim.log

clean:
	rm -rf obj_dir sim.log
